//--- compile.f
+incdir+.
core_pkg.sv
core_controller.sv
fetch_stage.sv
exec_stage.sv
mem_stage.sv
trap_unit.sv
core_top.sv
tb_core.sv

//--- Bender.yml
package:
  name: core_subsystem

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - core_controller.sv
  - fetch_stage.sv
  - exec_stage.sv
  - mem_stage.sv
  - trap_unit.sv
  - core_top.sv
  - target: simulation
    files:
      - tb_core.sv

//--- tb_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core;

    import core_pkg::*;

    // Worst case per event is about 14 cycles with the model latencies below
    localparam int N_EVENTS    = 27;
    localparam int WORST_CYC   = 16;
    localparam int CYCLE_LIMIT = 8 + N_EVENTS * WORST_CYC + 64;

    typedef struct packed {
        logic    is_trap;
        retire_t ret;
        trap_t   trp;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  irq;
    logic                  imem_req_valid;
    logic [`CORE_XLEN-1:0] imem_addr;
    logic                  imem_rsp_valid;
    logic [`CORE_XLEN-1:0] imem_rsp_data;
    logic                  dmem_req_valid;
    mem_req_t              dmem_req;
    logic                  dmem_rsp_valid;
    logic [`CORE_XLEN-1:0] dmem_rsp_data;
    logic                  retire_valid;
    retire_t               retire;
    logic                  trap_valid;
    trap_t                 trap;

    // Memories seen by the DUT
    logic [31:0] prog [256];
    logic [31:0] dmem [256];

    // Reference machine state
    logic [31:0] sregs [`CORE_NREGS];
    logic [31:0] sdmem [256];
    logic [31:0] spc;
    logic [31:0] sretired;
    trap_cause_e scause;
    logic [31:0] sepc;

    // Data requests of the instruction in flight, as issued and as predicted
    mem_req_t    dmem_seen [$];
    mem_req_t    dmem_expected [$];

    integer      seed = 32'hbfa86153;
    int          imem_lat;
    int          dmem_lat;
    logic [31:0] imem_held_addr;
    mem_req_t    dmem_held;
    int          cycle_cnt;
    int          event_cnt;
    int          check_cnt;
    int          err_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    string       cur_test;

    core_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .irq            (irq),
        .imem_req_valid (imem_req_valid),
        .imem_addr      (imem_addr),
        .imem_rsp_valid (imem_rsp_valid),
        .imem_rsp_data  (imem_rsp_data),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_data  (dmem_rsp_data),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .trap_valid     (trap_valid),
        .trap           (trap)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [3:0] rs2,
                                           input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'h5a5a_0000 ^ (addr << 14) ^ addr;
    endfunction

    function automatic void expect_request(input logic [31:0] addr, input logic [31:0] wdata,
                                           input logic we);
        mem_req_t req;
        req.addr  = addr;
        req.wdata = wdata;
        req.we    = we;
        dmem_expected.push_back(req);
    endfunction

    // Executes one instruction, or takes the interrupt, on the shadow state
    function automatic expect_t ref_step(input logic take_irq);
        expect_t     e;
        instr_t      ins;
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] wd;
        e = '0;
        if (take_irq) begin
            e.is_trap   = 1'b1;
            e.trp.cause = CAUSE_IRQ;
            e.trp.epc   = spc;
            scause      = CAUSE_IRQ;
            sepc        = spc;
            spc         = `CORE_TRAP_VEC;
            return e;
        end
        ins      = instr_t'(prog[spc[9:2]]);
        a        = sregs[ins.rs1];
        imm      = {{16{ins.imm[15]}}, ins.imm};
        addr     = a + imm;
        wd       = '0;
        e.ret.pc = spc;
        e.ret.rd = ins.rd;
        e.ret.we = 1'b1;
        case (ins.op)
            ADD:    wd = a + sregs[ins.rs2];
            SUB:    wd = a - sregs[ins.rs2];
            AND:    wd = a & sregs[ins.rs2];
            XOR:    wd = a ^ sregs[ins.rs2];
            ADDI:   wd = a + imm;
            LW: begin
                wd = sdmem[addr[9:2]];
                expect_request(addr, 32'h0, 1'b0);
            end
            AMOADD: begin
                wd = sdmem[addr[9:2]];
                expect_request(addr, 32'h0, 1'b0);
            end
            SW: begin
                sdmem[addr[9:2]] = sregs[ins.rs2];
                e.ret.we         = 1'b0;
                expect_request(addr, sregs[ins.rs2], 1'b1);
            end
            CSRR: begin
                case (ins.imm[1:0])
                    2'd0:    wd = sretired;
                    2'd1:    wd = 32'(scause);
                    2'd2:    wd = sepc;
                    default: wd = '0;
                endcase
            end
            default: begin
                e.is_trap   = 1'b1;
                e.trp.cause = CAUSE_ILLEGAL;
                e.trp.epc   = spc;
                scause      = CAUSE_ILLEGAL;
                sepc        = spc;
                spc         = `CORE_TRAP_VEC;
                return e;
            end
        endcase
        e.ret.wdata = wd;
        if (e.ret.we && ins.rd != 4'd0) begin
            sregs[ins.rd] = wd;
        end
        // Sum is formed after rd has taken the old word
        if (ins.op == AMOADD) begin
            sdmem[addr[9:2]] = wd + sregs[ins.rs2];
            expect_request(addr, sdmem[addr[9:2]], 1'b1);
        end
        sretired = sretired + 1;
        spc      = spc + 4;
        return e;
    endfunction

    task automatic check_val(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("Mismatch in test %s, %s: expected %h, actual %h",
                     cur_test, field, exp, act);
        end
    endtask

    task automatic check_requests();
        mem_req_t exp_req;
        mem_req_t act_req;
        if (dmem_seen.size() != dmem_expected.size()) begin
            err_cnt++;
            $display("Error in test %s: core issued %0d data requests where %0d were expected",
                     cur_test, dmem_seen.size(), dmem_expected.size());
        end else begin
            foreach (dmem_expected[i]) begin
                exp_req = dmem_expected[i];
                act_req = dmem_seen[i];
                check_val("data addr", exp_req.addr, act_req.addr);
                check_val("data we", 32'(exp_req.we), 32'(act_req.we));
                if (exp_req.we) begin
                    check_val("data wdata", exp_req.wdata, act_req.wdata);
                end
            end
        end
        dmem_seen.delete();
        dmem_expected.delete();
    endtask

    task automatic check_event();
        expect_t e;
        e = ref_step(irq);
        event_cnt++;
        if (e.is_trap && !trap_valid) begin
            err_cnt++;
            $display("Error in test %s: core retired pc %h where a trap was expected",
                     cur_test, retire.pc);
        end else if (e.is_trap) begin
            check_val("trap cause", 32'(e.trp.cause), 32'(trap.cause));
            check_val("trap epc", e.trp.epc, trap.epc);
            if (retire_valid) begin
                err_cnt++;
                $display("Error in test %s: core retired pc %h in the same cycle as the trap",
                         cur_test, retire.pc);
            end
        end else if (!retire_valid) begin
            err_cnt++;
            $display("Error in test %s: core trapped at %h where pc %h should retire",
                     cur_test, trap.epc, e.ret.pc);
        end else begin
            if (trap_valid) begin
                err_cnt++;
                $display("Error in test %s: core trapped at %h while pc %h retired",
                         cur_test, trap.epc, e.ret.pc);
            end
            check_val("retire pc", e.ret.pc, retire.pc);
            check_val("retire rd", 32'(e.ret.rd), 32'(retire.rd));
            check_val("retire we", 32'(e.ret.we), 32'(retire.we));
            if (e.ret.we) begin
                check_val("retire wdata", e.ret.wdata, retire.wdata);
            end
        end
        check_requests();
    endtask

    // Strobes are sampled mid-cycle, away from the input updates
    always @(negedge clk) begin
        if (rst_n && (retire_valid || trap_valid)) begin
            check_event();
        end
    end

    // Instruction memory, 1 to 3 cycles
    always begin
        @(negedge clk);
        if (rst_n && imem_req_valid) begin
            imem_held_addr = imem_addr;
            check_val("fetch address", spc, imem_held_addr);
            imem_lat = 1 + ($unsigned($random(seed)) % 3);
            repeat (imem_lat) @(posedge clk);
            #1;
            imem_rsp_valid = 1'b1;
            imem_rsp_data  = prog[imem_held_addr[9:2]];
            @(posedge clk);
            #1;
            imem_rsp_valid = 1'b0;
        end
    end

    // Data memory, 1 to 4 cycles, stores also answered
    always begin
        @(negedge clk);
        if (rst_n && dmem_req_valid) begin
            dmem_held = dmem_req;
            dmem_seen.push_back(dmem_held);
            dmem_lat  = 1 + ($unsigned($random(seed)) % 4);
            repeat (dmem_lat) @(posedge clk);
            #1;
            dmem_rsp_valid = 1'b1;
            dmem_rsp_data  = dmem[dmem_held.addr[9:2]];
            if (dmem_held.we) begin
                dmem[dmem_held.addr[9:2]] = dmem_held.wdata;
            end
            @(posedge clk);
            #1;
            dmem_rsp_valid = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout in test %s: run did not finish within %0d cycles",
                     cur_test, CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic init_memories();
        for (int i = 0; i < 256; i++) begin
            prog[i]  = '0;
            dmem[i]  = fill_word(i * 4);
            sdmem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < `CORE_NREGS; i++) begin
            sregs[i] = '0;
        end
        spc      = `CORE_RESET_PC;
        sretired = '0;
        scause   = CAUSE_IRQ;
        sepc     = '0;
    endtask

    task automatic load_program();
        // ALU
        prog[0]  = encode(ADDI, 1, 0, 0, 16'h0123);
        prog[1]  = encode(ADDI, 2, 0, 0, 16'hfffb);
        prog[2]  = encode(ADD, 3, 1, 2, 16'h0);
        prog[3]  = encode(SUB, 4, 1, 2, 16'h0);
        prog[4]  = encode(AND, 5, 3, 2, 16'h0);
        prog[5]  = encode(XOR, 6, 4, 1, 16'h0);
        prog[6]  = encode(ADDI, 0, 1, 0, 16'h0007);
        prog[7]  = encode(ADD, 7, 0, 1, 16'h0);
        // Stores and loads around base 0x40
        prog[8]  = encode(ADDI, 8, 0, 0, 16'h0040);
        prog[9]  = encode(SW, 0, 8, 6, 16'h0000);
        prog[10] = encode(SW, 0, 8, 3, 16'h0008);
        prog[11] = encode(LW, 9, 8, 0, 16'h0000);
        prog[12] = encode(LW, 10, 8, 0, 16'h0008);
        prog[13] = encode(LW, 11, 8, 0, 16'h0004);
        // Atomic adds then read back
        prog[14] = encode(ADDI, 12, 0, 0, 16'h0025);
        prog[15] = encode(AMOADD, 13, 8, 12, 16'h0008);
        prog[16] = encode(LW, 14, 8, 0, 16'h0008);
        prog[17] = encode(AMOADD, 15, 8, 12, 16'h0010);
        prog[18] = encode(LW, 1, 8, 0, 16'h0010);
        prog[19] = encode(4'hf, 2, 1, 1, 16'h0);
        // Trap handler at the vector reads the CSRs
        prog[64] = encode(CSRR, 1, 0, 0, 16'h0000);
        prog[65] = encode(CSRR, 2, 0, 0, 16'h0001);
        prog[66] = encode(CSRR, 3, 0, 0, 16'h0002);
        prog[67] = encode(ADDI, 4, 1, 0, 16'h0001);
    endtask

    task automatic run_test(input string name, input int n_events);
        int err_start;
        int target;
        cur_test  = name;
        err_start = err_cnt;
        target    = event_cnt + n_events;
        while (event_cnt < target) begin
            @(posedge clk);
            #1;
        end
        test_cnt++;
        if (err_cnt != err_start) begin
            test_fail_cnt++;
        end
        $display("%s: %s, %0d events, %0d errors", name,
                 (err_cnt == err_start) ? "passed" : "failed", n_events, err_cnt - err_start);
    endtask

    initial begin
        rst_n          = 1'b0;
        irq            = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp_data  = '0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_data  = '0;
        cycle_cnt      = 0;
        event_cnt      = 0;
        check_cnt      = 0;
        err_cnt        = 0;
        test_cnt       = 0;
        test_fail_cnt  = 0;
        cur_test       = "reset";
        init_memories();
        load_program();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_test("alu", 8);
        run_test("load_store", 6);
        run_test("amoadd", 5);
        run_test("illegal", 1);
        run_test("csrr", 3);
        // Core is now in the first fetch cycle of the next instruction
        irq = 1'b1;
        run_test("interrupt", 1);
        irq = 1'b0;
        run_test("csrr_after_irq", 3);
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- core_top.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  irq,
    output logic                  imem_req_valid,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  logic                  imem_rsp_valid,
    input  logic [`CORE_XLEN-1:0] imem_rsp_data,
    output logic                  dmem_req_valid,
    output core_pkg::mem_req_t    dmem_req,
    input  logic                  dmem_rsp_valid,
    input  logic [`CORE_XLEN-1:0] dmem_rsp_data,
    output logic                  retire_valid,
    output core_pkg::retire_t     retire,
    output logic                  trap_valid,
    output core_pkg::trap_t       trap
);

    import core_pkg::*;

    logic                  fetch_stage_valid;
    logic                  fetch_stage_ready;
    logic                  exec_stage_valid;
    logic                  exec_stage_ready;
    logic                  exec_phase;
    logic                  mem_stage_valid;
    logic                  mem_stage_ready;
    logic                  reg_d_en;
    logic                  csr_en;
    logic                  instr_done;
    logic                  check_interrupt;
    logic                  exception_valid;
    logic                  interrupt_valid;
    logic                  trap_redirect;
    ctrl_path_e            ctrl_path;
    instr_t                instr;
    retire_t               exec_retire;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] load_data;
    logic [`CORE_XLEN-1:0] store_data;
    logic [`CORE_XLEN-1:0] mem_addr;
    logic [`CORE_XLEN-1:0] csr_rdata;

    assign retire_valid = instr_done;
    assign retire = '{pc: pc, rd: exec_retire.rd, wdata: exec_retire.wdata,
                      we: exec_retire.we};

    core_controller u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .fetch_stage_valid (fetch_stage_valid),
        .fetch_stage_ready (fetch_stage_ready),
        .exec_stage_valid  (exec_stage_valid),
        .exec_stage_ready  (exec_stage_ready),
        .exec_phase        (exec_phase),
        .ctrl_path         (ctrl_path),
        .mem_stage_valid   (mem_stage_valid),
        .mem_stage_ready   (mem_stage_ready),
        .reg_d_en          (reg_d_en),
        .csr_en            (csr_en),
        .instr_done        (instr_done),
        .check_interrupt   (check_interrupt),
        .exception_valid   (exception_valid),
        .interrupt_valid   (interrupt_valid)
    );

    fetch_stage u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .fetch_stage_valid (fetch_stage_valid),
        .fetch_stage_ready (fetch_stage_ready),
        .imem_req_valid    (imem_req_valid),
        .imem_addr         (imem_addr),
        .imem_rsp_valid    (imem_rsp_valid),
        .imem_rsp_data     (imem_rsp_data),
        .instr_done        (instr_done),
        .trap_redirect     (trap_redirect),
        .pc                (pc),
        .instr             (instr)
    );

    exec_stage u_exec (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr            (instr),
        .exec_stage_valid (exec_stage_valid),
        .exec_phase       (exec_phase),
        .reg_d_en         (reg_d_en),
        .csr_en           (csr_en),
        .exec_stage_ready (exec_stage_ready),
        .exception_valid  (exception_valid),
        .ctrl_path        (ctrl_path),
        .load_data        (load_data),
        .csr_rdata        (csr_rdata),
        .store_data       (store_data),
        .mem_addr         (mem_addr),
        .retire           (exec_retire)
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_stage_valid (mem_stage_valid),
        .exec_phase      (exec_phase),
        .mem_addr        (mem_addr),
        .store_data      (store_data),
        .instr           (instr),
        .mem_stage_ready (mem_stage_ready),
        .dmem_req_valid  (dmem_req_valid),
        .dmem_req        (dmem_req),
        .dmem_rsp_valid  (dmem_rsp_valid),
        .dmem_rsp_data   (dmem_rsp_data),
        .load_data       (load_data)
    );

    trap_unit u_trap (
        .clk             (clk),
        .rst_n           (rst_n),
        .check_interrupt (check_interrupt),
        .irq             (irq),
        .exception_valid (exception_valid),
        .instr_done      (instr_done),
        .pc              (pc),
        .csr_en          (csr_en),
        .csr_sel         (instr.imm[1:0]),
        .interrupt_valid (interrupt_valid),
        .trap_redirect   (trap_redirect),
        .csr_rdata       (csr_rdata),
        .trap_valid      (trap_valid),
        .trap            (trap)
    );

endmodule

//--- trap_unit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module trap_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  check_interrupt,
    input  logic                  irq,
    input  logic                  exception_valid,
    input  logic                  instr_done,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic                  csr_en,
    input  logic [1:0]            csr_sel,
    output logic                  interrupt_valid,
    output logic                  trap_redirect,
    output logic [`CORE_XLEN-1:0] csr_rdata,
    output logic                  trap_valid,
    output core_pkg::trap_t       trap
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] retired_cnt;
    trap_t                 trap_q;

    assign interrupt_valid = check_interrupt && irq;
    assign trap_redirect   = interrupt_valid || exception_valid;
    assign trap_valid      = trap_redirect;

    // PC has not advanced yet, so it is the epc for both causes
    assign trap = '{cause: interrupt_valid ? CAUSE_IRQ : CAUSE_ILLEGAL, epc: pc};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_cnt <= '0;
            trap_q      <= '0;
        end else begin
            if (instr_done) retired_cnt <= retired_cnt + 1'b1;
            if (trap_redirect) trap_q <= trap;
        end
    end

    always_comb begin
        csr_rdata = '0;
        if (csr_en) begin
            case (csr_sel)
                2'd0:    csr_rdata = retired_cnt;
                2'd1:    csr_rdata = `CORE_XLEN'(trap_q.cause);
                2'd2:    csr_rdata = trap_q.epc;
                default: csr_rdata = '0;
            endcase
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_stage_valid,
    input  logic                  exec_phase,
    input  logic [`CORE_XLEN-1:0] mem_addr,
    input  logic [`CORE_XLEN-1:0] store_data,
    input  core_pkg::instr_t      instr,
    output logic                  mem_stage_ready,
    output logic                  dmem_req_valid,
    output core_pkg::mem_req_t    dmem_req,
    input  logic                  dmem_rsp_valid,
    input  logic [`CORE_XLEN-1:0] dmem_rsp_data,
    output logic [`CORE_XLEN-1:0] load_data
);

    import core_pkg::*;

    logic                  valid_q;
    logic                  is_write;
    logic                  rd_rsp;
    logic [`CORE_XLEN-1:0] load_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_stage_valid;
        end
    end

    // Second atomic pass stores the sum, the first one reads
    assign is_write = (instr.op == SW) || (instr.op == AMOADD && exec_phase);

    // One request on the first cycle of each MEM visit
    assign dmem_req_valid = mem_stage_valid && !valid_q;
    assign dmem_req       = '{addr: mem_addr, wdata: store_data, we: is_write};

    assign mem_stage_ready = mem_stage_valid && dmem_rsp_valid;
    assign rd_rsp          = mem_stage_ready && !is_write;

    always_ff @(posedge clk) begin
        if (rd_rsp) begin
            load_q <= dmem_rsp_data;
        end
    end

    // Bypass so rd can be written in the response cycle
    assign load_data = rd_rsp ? dmem_rsp_data : load_q;

endmodule

//--- exec_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::instr_t      instr,
    input  logic                  exec_stage_valid,
    input  logic                  exec_phase,
    input  logic                  reg_d_en,
    input  logic                  csr_en,
    output logic                  exec_stage_ready,
    output logic                  exception_valid,
    output core_pkg::ctrl_path_e  ctrl_path,
    input  logic [`CORE_XLEN-1:0] load_data,
    input  logic [`CORE_XLEN-1:0] csr_rdata,
    output logic [`CORE_XLEN-1:0] store_data,
    output logic [`CORE_XLEN-1:0] mem_addr,
    output core_pkg::retire_t     retire
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm_ext;
    logic [`CORE_XLEN-1:0] alu_res;
    logic [`CORE_XLEN-1:0] wb_data;
    logic                  illegal;
    logic                  writes_rd;

    always_comb begin
        illegal   = 1'b0;
        writes_rd = 1'b1;
        ctrl_path = CTRL_EXEC;
        case (instr.op)
            ADD, SUB, AND, XOR, ADDI, CSRR: ctrl_path = CTRL_EXEC;
            LW:      ctrl_path = CTRL_MEM;
            AMOADD:  ctrl_path = CTRL_AMO;
            SW: begin
                ctrl_path = CTRL_MEM;
                writes_rd = 1'b0;
            end
            default: begin
                illegal   = 1'b1;
                writes_rd = 1'b0;
            end
        endcase
    end

    // Single-cycle execute, only the first pass can be illegal
    assign exec_stage_ready = exec_stage_valid;
    assign exception_valid  = exec_stage_valid && !exec_phase && illegal;

    assign rs1_val = (instr.rs1 == '0) ? '0 : regs[instr.rs1];
    assign rs2_val = (instr.rs2 == '0) ? '0 : regs[instr.rs2];
    assign imm_ext = {{(`CORE_XLEN-16){instr.imm[15]}}, instr.imm};

    always_comb begin
        case (instr.op)
            ADD:     alu_res = rs1_val + rs2_val;
            SUB:     alu_res = rs1_val - rs2_val;
            AND:     alu_res = rs1_val & rs2_val;
            XOR:     alu_res = rs1_val ^ rs2_val;
            ADDI:    alu_res = rs1_val + imm_ext;
            default: alu_res = '0;
        endcase
    end

    assign mem_addr = rs1_val + imm_ext;

    // Atomic sum uses rs2 as read after rd has taken the old word
    assign store_data = (instr.op == AMOADD) ? load_data + rs2_val : rs2_val;

    always_comb begin
        if (instr.op == LW || instr.op == AMOADD) begin
            wb_data = load_data;
        end else if (instr.op == CSRR && csr_en) begin
            wb_data = csr_rdata;
        end else begin
            wb_data = alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_d_en && writes_rd && instr.rd != '0) begin
            regs[instr.rd] <= wb_data;
        end
    end

    // PC field is filled in at the top level
    assign retire = '{pc: '0, rd: instr.rd, wdata: wb_data, we: writes_rd};

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_stage_valid,
    output logic                  fetch_stage_ready,
    output logic                  imem_req_valid,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  logic                  imem_rsp_valid,
    input  logic [`CORE_XLEN-1:0] imem_rsp_data,
    input  logic                  instr_done,
    input  logic                  trap_redirect,
    output logic [`CORE_XLEN-1:0] pc,
    output core_pkg::instr_t      instr
);

    import core_pkg::*;

    logic valid_q;

    // Cleared on a redirect so the refetch after an interrupt sees a new start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_stage_valid && !trap_redirect;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (trap_redirect) begin
            pc <= `CORE_TRAP_VEC;
        end else if (instr_done) begin
            pc <= pc + `CORE_XLEN'd4;
        end
    end

    // No request when the fetch is being pre-empted
    assign imem_req_valid    = fetch_stage_valid && !valid_q && !trap_redirect;
    assign imem_addr         = pc;
    assign fetch_stage_ready = fetch_stage_valid && imem_rsp_valid;

    always_ff @(posedge clk) begin
        if (fetch_stage_ready) begin
            instr <= instr_t'(imem_rsp_data);
        end
    end

endmodule

//--- core_controller.sv
`timescale 1ns/1ps

module core_controller (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 fetch_stage_valid,
    input  logic                 fetch_stage_ready,
    output logic                 exec_stage_valid,
    input  logic                 exec_stage_ready,
    output logic                 exec_phase,
    input  core_pkg::ctrl_path_e ctrl_path,
    output logic                 mem_stage_valid,
    input  logic                 mem_stage_ready,
    output logic                 reg_d_en,
    output logic                 csr_en,
    output logic                 instr_done,
    output logic                 check_interrupt,
    input  logic                 exception_valid,
    input  logic                 interrupt_valid
);

    import core_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_0,
        FETCH_1,
        EXEC_0,
        MEM_0,
        EXEC_1,
        MEM_1
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_mem_op;
    logic   two_phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        is_mem_op = (ctrl_path == CTRL_MEM) || (ctrl_path == CTRL_AMO);
        two_phase = (ctrl_path == CTRL_AMO);
    end

    always_comb begin
        state_nxt = state;
        // A trap abandons the instruction and restarts at fetch
        if (exception_valid || interrupt_valid) begin
            state_nxt = FETCH_0;
        end else begin
            case (state)
                IDLE:    state_nxt = FETCH_0;
                FETCH_0: state_nxt = FETCH_1;
                FETCH_1: if (fetch_stage_ready) state_nxt = EXEC_0;
                EXEC_0:  if (exec_stage_ready) state_nxt = is_mem_op ? MEM_0 : FETCH_0;
                MEM_0:   if (mem_stage_ready) state_nxt = two_phase ? EXEC_1 : FETCH_0;
                EXEC_1:  if (exec_stage_ready) state_nxt = MEM_1;
                MEM_1:   if (mem_stage_ready) state_nxt = FETCH_0;
                default: state_nxt = IDLE;
            endcase
        end
    end

    assign check_interrupt   = (state == FETCH_0);
    assign fetch_stage_valid = (state == FETCH_0) || (state == FETCH_1);
    assign exec_stage_valid  = (state == EXEC_0) || (state == EXEC_1);
    assign mem_stage_valid   = (state == MEM_0) || (state == MEM_1);
    assign exec_phase        = (state == EXEC_1) || (state == MEM_1);

    // Memory ops write rd once the first data response is in
    always_comb begin
        if (exception_valid) begin
            reg_d_en = 1'b0;
        end else if (is_mem_op) begin
            reg_d_en = (state == MEM_0) && mem_stage_ready;
        end else begin
            reg_d_en = (state == EXEC_0) && exec_stage_ready;
        end
    end

    assign csr_en = exec_stage_valid && exec_stage_ready;

    // Any return to fetch other than from reset or a trap retires
    assign instr_done = (state != FETCH_0) && (state != IDLE)
                     && (state_nxt == FETCH_0) && !exception_valid;

endmodule

//--- core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    // Instruction opcodes, any code not listed traps as illegal
    typedef enum logic [3:0] {
        ADD    = 4'h0,
        SUB    = 4'h1,
        AND    = 4'h2,
        XOR    = 4'h3,
        ADDI   = 4'h4,
        LW     = 4'h5,
        SW     = 4'h6,
        AMOADD = 4'h7,
        CSRR   = 4'h8
    } opcode_e;

    // Path through the controller FSM
    typedef enum logic [1:0] {
        CTRL_EXEC = 2'd0,
        CTRL_MEM  = 2'd1,
        CTRL_AMO  = 2'd2
    } ctrl_path_e;

    typedef enum logic {
        CAUSE_IRQ     = 1'b0,
        CAUSE_ILLEGAL = 1'b1
    } trap_cause_e;

    typedef struct packed {
        opcode_e     op;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
        logic                  we;
    } mem_req_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [3:0]            rd;
        logic [`CORE_XLEN-1:0] wdata;
        logic                  we;
    } retire_t;

    typedef struct packed {
        trap_cause_e           cause;
        logic [`CORE_XLEN-1:0] epc;
    } trap_t;

endpackage

//--- core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define CORE_XLEN 32

// Register file size, register 0 is hard-wired to zero
`define CORE_NREGS 16

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Fetch address taken on any interrupt or exception
`define CORE_TRAP_VEC 32'h0000_0100

`endif
